// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP      = tb_rv_core
FILELIST = project.f
OBJ_DIR  = obj_dir
PASS_MSG = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath sizes
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// accepted major opcodes
`define OPC_OP      7'b0110011  // register-register alu
`define OPC_OP_IMM  7'b0010011  // register-immediate alu
`define OPC_LUI     7'b0110111

// funct3 encodings, shared by OP and OP-IMM
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101  // srl / sra, split by funct7
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct7 for sub and sra
`define F7_ALT      7'b0100000

`endif

// File: core_pkg.sv
`default_nettype none

`include "core_consts.svh"

package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10  // lui, operand b straight through
    } alu_op_e;

    // decode -> execute
    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`XLEN-1:0]       rs1_val;  // register file value at decode
        logic [`XLEN-1:0]       rs2_val;
        logic [`XLEN-1:0]       imm;
        logic                   use_imm;
        alu_op_e                alu_op;
    } decoded_t;

    // execute -> result, also the forwarding payload
    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } result_t;

endpackage

`default_nettype wire

// File: project.f
+incdir+.
core_pkg.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core_top.sv
tb_rv_core.sv

// File: rv_core_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module rv_core_top (
    input  wire                     clk_10M,
    input  wire                     locked,      // async, active low
    input  logic                    inst_valid_i,
    input  logic [`XLEN-1:0]        inst_i,
    output logic                    wb_valid_o,
    output logic [`REG_ADDR_W-1:0]  wb_rd_o,
    output logic [`XLEN-1:0]        wb_data_o,
    output logic                    illegal_o
);

    import core_pkg::*;

    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    decoded_t               id_ex;
    result_t                ex_res;
    result_t                res;

    rv_decode u_decode (
        .clk_10M      (clk_10M),
        .locked       (locked),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_addr_o   (rs1_addr),   // to register file
        .rs2_addr_o   (rs2_addr),
        .id_ex_o      (id_ex),
        .illegal_o    (illegal_o)
    );

    rv_execute u_execute (
        .clk_10M      (clk_10M),
        .locked       (locked),
        .id_ex_i      (id_ex),
        .res_i        (res),        // forwarded from result stage
        .ex_res_o     (ex_res)
    );

    rv_result u_result (
        .clk_10M      (clk_10M),
        .locked       (locked),
        .ex_res_i     (ex_res),
        .rs1_addr_i   (rs1_addr),
        .rs2_addr_i   (rs2_addr),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .res_o        (res),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

endmodule

`default_nettype wire

// File: rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module rv_decode (
    input  wire                     clk_10M,
    input  wire                     locked,
    input  logic                    inst_valid_i,
    input  logic [`XLEN-1:0]        inst_i,
    input  logic [`XLEN-1:0]        rs1_data_i,
    input  logic [`XLEN-1:0]        rs2_data_i,
    output logic [`REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [`REG_ADDR_W-1:0]  rs2_addr_o,
    output core_pkg::decoded_t      id_ex_o,
    output logic                    illegal_o
);

    import core_pkg::*;

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`XLEN-1:0]       imm_i;
    logic [`XLEN-1:0]       imm_u;
    logic                   legal;
    decoded_t               id_ex_d;
    decoded_t               id_ex_q;
    logic                   illegal_q;

    // funct3 to alu op, alt picks sub / sra
    function automatic alu_op_e f3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            `F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            `F3_SLL:     return ALU_SLL;
            `F3_SLT:     return ALU_SLT;
            `F3_SLTU:    return ALU_SLTU;
            `F3_XOR:     return ALU_XOR;
            `F3_SR:      return alt ? ALU_SRA : ALU_SRL;
            `F3_OR:      return ALU_OR;
            default:     return ALU_AND;
        endcase
    endfunction

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign imm_i  = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};  // sign extended
    assign imm_u  = {inst_i[31:12], 12'b0};

    always_comb begin
        legal           = 1'b1;
        id_ex_d         = '0;
        id_ex_d.rd      = inst_i[11:7];
        id_ex_d.rs1     = inst_i[19:15];
        id_ex_d.rs2     = inst_i[24:20];
        id_ex_d.imm     = imm_i;
        id_ex_d.alu_op  = ALU_ADD;
        case (opcode)
            `OPC_OP: begin
                id_ex_d.alu_op = f3_op(funct3, funct7 == `F7_ALT);
                if (funct7 == `F7_ALT)
                    legal = (funct3 == `F3_ADD_SUB) || (funct3 == `F3_SR);
                else
                    legal = (funct7 == 7'b0);
            end
            `OPC_OP_IMM: begin
                id_ex_d.use_imm = 1'b1;
                id_ex_d.rs2     = '0;  // no second source
                id_ex_d.alu_op  = f3_op(funct3, (funct3 == `F3_SR) && (funct7 == `F7_ALT));
                if (funct3 == `F3_SLL)
                    legal = (funct7 == 7'b0);
                else if (funct3 == `F3_SR)
                    legal = (funct7 == 7'b0) || (funct7 == `F7_ALT);
            end
            `OPC_LUI: begin
                id_ex_d.use_imm = 1'b1;
                id_ex_d.imm     = imm_u;
                id_ex_d.rs1     = '0;
                id_ex_d.rs2     = '0;
                id_ex_d.alu_op  = ALU_PASS_B;
            end
            default: legal = 1'b0;
        endcase
        id_ex_d.valid   = inst_valid_i && legal;
        id_ex_d.rs1_val = rs1_data_i;
        id_ex_d.rs2_val = rs2_data_i;
    end

    assign rs1_addr_o = id_ex_d.rs1;
    assign rs2_addr_o = id_ex_d.rs2;

    always_ff @(posedge clk_10M or negedge locked) begin
        if (!locked) begin
            id_ex_q   <= '0;
            illegal_q <= 1'b0;
        end else begin
            id_ex_q   <= id_ex_d;
            illegal_q <= inst_valid_i && !legal;  // dropped slot, bubble downstream
        end
    end

    assign id_ex_o   = id_ex_q;
    assign illegal_o = illegal_q;

    // an illegal slot never reaches execute
    assert property (@(posedge clk_10M) disable iff (!locked)
        !(illegal_o && id_ex_o.valid));

endmodule

`default_nettype wire

// File: rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module rv_execute (
    input  wire                 clk_10M,
    input  wire                 locked,
    input  core_pkg::decoded_t  id_ex_i,
    input  core_pkg::result_t   res_i,
    output core_pkg::result_t   ex_res_o
);

    import core_pkg::*;

    result_t            ex_res_q;
    logic [`XLEN-1:0]   op_a;
    logic [`XLEN-1:0]   rs2_fwd;
    logic [`XLEN-1:0]   op_b;
    logic [4:0]         shamt;
    logic [`XLEN-1:0]   alu_y;

    // newest producer wins, then register file value
    function automatic logic [`XLEN-1:0] fwd_sel(
        input logic [`REG_ADDR_W-1:0]   src,
        input logic [`XLEN-1:0]         rf_val,
        input result_t                  near,
        input result_t                  far
    );
        if (near.valid && (near.rd != '0) && (near.rd == src))
            return near.data;
        if (far.valid && (far.rd != '0) && (far.rd == src))
            return far.data;
        return rf_val;
    endfunction

    assign op_a    = fwd_sel(id_ex_i.rs1, id_ex_i.rs1_val, ex_res_q, res_i);
    assign rs2_fwd = fwd_sel(id_ex_i.rs2, id_ex_i.rs2_val, ex_res_q, res_i);
    assign op_b    = id_ex_i.use_imm ? id_ex_i.imm : rs2_fwd;
    assign shamt   = op_b[4:0];

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:    alu_y = op_a + op_b;
            ALU_SUB:    alu_y = op_a - op_b;
            ALU_SLL:    alu_y = op_a << shamt;
            ALU_SLT:    alu_y = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_y = {{(`XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_y = op_a ^ op_b;
            ALU_SRL:    alu_y = op_a >> shamt;
            ALU_SRA:    alu_y = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_y = op_a | op_b;
            ALU_AND:    alu_y = op_a & op_b;
            ALU_PASS_B: alu_y = op_b;  // lui
            default:    alu_y = '0;
        endcase
    end

    always_ff @(posedge clk_10M or negedge locked) begin
        if (!locked) begin
            ex_res_q <= '0;
        end else begin
            ex_res_q.valid <= id_ex_i.valid;
            ex_res_q.rd    <= id_ex_i.rd;
            ex_res_q.data  <= alu_y;
        end
    end

    assign ex_res_o = ex_res_q;

    // one slot in, one slot out, no bubbles created here
    assert property (@(posedge clk_10M) disable iff (!locked)
        ex_res_o.valid |-> $past(id_ex_i.valid));

endmodule

`default_nettype wire

// File: rv_result.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module rv_result (
    input  wire                     clk_10M,
    input  wire                     locked,
    input  core_pkg::result_t       ex_res_i,
    input  logic [`REG_ADDR_W-1:0]  rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0]  rs2_addr_i,
    output logic [`XLEN-1:0]        rs1_data_o,
    output logic [`XLEN-1:0]        rs2_data_o,
    output core_pkg::result_t       res_o,
    output logic                    wb_valid_o,
    output logic [`REG_ADDR_W-1:0]  wb_rd_o,
    output logic [`XLEN-1:0]        wb_data_o
);

    import core_pkg::*;

    logic [`XLEN-1:0]   regs [`NUM_REGS];
    result_t            res_q;

    // result register and register file share the edge
    always_ff @(posedge clk_10M or negedge locked) begin
        if (!locked) begin
            res_q <= '0;
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            res_q <= ex_res_i;
            if (ex_res_i.valid && (ex_res_i.rd != '0))
                regs[ex_res_i.rd] <= ex_res_i.data;
        end
    end

    // x0 hardwired to zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    assign res_o      = res_q;  // second forwarding source
    assign wb_valid_o = res_q.valid && (res_q.rd != '0);
    assign wb_rd_o    = res_q.rd;
    assign wb_data_o  = res_q.data;

    assert property (@(posedge clk_10M) disable iff (!locked)
        wb_valid_o |-> (wb_rd_o != '0));

endmodule

`default_nettype wire

// File: tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module tb_rv_core;

    localparam int HALF_PERIOD = 50;  // 100 ns clock
    localparam logic [31:0] SEED = 32'd72;

    typedef struct packed {
        logic [31:0] cyc;  // cycle count when the pulse is due
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_exp_t;

    logic                   clk_10M = 1'b0;
    logic                   locked;
    logic                   inst_valid_i;
    logic [`XLEN-1:0]       inst_i;
    logic                   wb_valid_o;
    logic [`REG_ADDR_W-1:0] wb_rd_o;
    logic [`XLEN-1:0]       wb_data_o;
    logic                   illegal_o;

    logic [31:0]  lfsr_state = SEED;
    logic [31:0]  model_regs [`NUM_REGS];
    int unsigned  cycle = 0;
    int unsigned  errors = 0;
    int unsigned  checks = 0;
    int unsigned  err_start = 0;
    int unsigned  tests_ok = 0;
    int unsigned  tests_bad = 0;
    wb_exp_t      wb_q [$];
    int unsigned  ill_q [$];

    rv_core_top DUT (
        .clk_10M      (clk_10M),
        .locked       (locked),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .illegal_o    (illegal_o)
    );

    always #HALF_PERIOD clk_10M = ~clk_10M;

    always @(posedge clk_10M) cycle <= cycle + 1;

    // one lfsr step per returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    // {illegal, writes back, rd, value} from the rv32i definitions
    function automatic logic [38:0] ref_result(input logic [31:0] inst);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] y;
        logic        ok;
        logic        alt;
        opc = inst[6:0];
        f3  = inst[14:12];
        f7  = inst[31:25];
        rd  = inst[11:7];
        a   = model_regs[inst[19:15]];
        b   = model_regs[inst[24:20]];
        alt = (f7 == `F7_ALT);
        y   = '0;
        ok  = 1'b0;
        if (opc == `OPC_LUI) begin
            y  = {inst[31:12], 12'h000};
            ok = 1'b1;
        end else if (opc == `OPC_OP || opc == `OPC_OP_IMM) begin
            if (opc == `OPC_OP_IMM) begin
                b   = {{20{inst[31]}}, inst[31:20]};
                ok  = (f3 != `F3_SLL && f3 != `F3_SR) || f7 == 7'd0 || (alt && f3 == `F3_SR);
                alt = alt && (f3 == `F3_SR);  // addi has no subtract form
            end else begin
                ok = f7 == 7'd0 || (alt && (f3 == `F3_ADD_SUB || f3 == `F3_SR));
            end
            case (f3)
                `F3_ADD_SUB: y = alt ? a - b : a + b;
                `F3_SLL:     y = a << b[4:0];
                `F3_SLT:     y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                `F3_SLTU:    y = (a < b) ? 32'd1 : 32'd0;
                `F3_XOR:     y = a ^ b;
                `F3_SR:      y = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                `F3_OR:      y = a | b;
                default:     y = a & b;
            endcase
        end
        return {!ok, ok && (rd != 5'd0), rd, y};
    endfunction

    function automatic logic [31:0] rand_inst();
        logic [31:0] c;
        logic [31:0] regs;
        logic [31:0] f;
        logic [31:0] x;
        logic [11:0] imm;
        logic [6:0]  opc;
        c    = rand_bits(3);
        regs = rand_bits(9);  // x0..x7 only, frequent dependencies
        f    = rand_bits(4);
        x    = rand_bits(12);
        imm  = x[11:0];
        case (c[2:0])
            3'd0, 3'd1, 3'd2: begin
                return enc_r(f[3] ? `F7_ALT : 7'd0, {2'b00, regs[8:6]}, {2'b00, regs[5:3]},
                             f[2:0], {2'b00, regs[2:0]});
            end
            3'd3, 3'd4, 3'd5: begin
                if (f[1:0] == 2'b01)
                    imm[11:5] = (f[3] && f[2]) ? `F7_ALT : 7'd0;  // shift amount forms
                return enc_i(imm, {2'b00, regs[5:3]}, f[2:0], {2'b00, regs[2:0]});
            end
            3'd6: return {imm, regs[7:0], 2'b00, regs[2:0], `OPC_LUI};
            default: begin
                opc = imm[6:0];
                if (opc == `OPC_OP || opc == `OPC_OP_IMM || opc == `OPC_LUI)
                    opc = 7'b0000011;
                return {imm, regs[4:0], f[2:0], regs[8:4], opc};
            end
        endcase
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk_10M);
            inst_valid_i = 1'b0;
        end
    endtask

    // queue the expected events, step the model, then drive
    task automatic issue(input logic [31:0] inst, input int gap);
        logic [38:0] ev;
        wb_exp_t     w;
        @(negedge clk_10M);
        ev = ref_result(inst);
        if (ev[38])
            ill_q.push_back(cycle + 1);
        if (ev[37]) begin
            w.cyc  = cycle + 3;
            w.rd   = ev[36:32];
            w.data = ev[31:0];
            wb_q.push_back(w);
            model_regs[ev[36:32]] = ev[31:0];
        end
        inst_valid_i = 1'b1;
        inst_i       = inst;
        idle(gap);
    endtask

    task automatic drain();
        int i;
        idle(1);
        i = 0;
        while ((wb_q.size() != 0 || ill_q.size() != 0) && i < 20) begin
            @(negedge clk_10M);
            i++;
        end
        if (wb_q.size() != 0 || ill_q.size() != 0) begin
            $display("timeout: %0d write-backs and %0d illegal pulses never arrived",
                     wb_q.size(), ill_q.size());
            errors++;
            wb_q.delete();
            ill_q.delete();
        end
        idle(2);  // catch stray pulses
    endtask

    task automatic finish_test(input string name);
        if (errors == err_start) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", name, errors - err_start);
            tests_bad++;
        end
        err_start = errors;
    endtask

    always @(negedge clk_10M) begin : compare
        wb_exp_t     w;
        int unsigned ic;
        if (locked && wb_valid_o) begin
            if (wb_q.size() == 0) begin
                $display("write-back to x%0d at %0t was not expected", wb_rd_o, $time);
                errors++;
            end else begin
                w = wb_q.pop_front();
                checks++;
                assert (wb_rd_o == w.rd && wb_data_o == w.data && cycle == w.cyc) else begin
                    $display("Mismatch at %0t: x%0d=%h cycle %0d, expected x%0d=%h cycle %0d",
                             $time, wb_rd_o, wb_data_o, cycle, w.rd, w.data, w.cyc);
                    errors++;
                end
            end
        end
        if (locked && illegal_o) begin
            if (ill_q.size() == 0) begin
                $display("illegal pulse at %0t was not expected", $time);
                errors++;
            end else begin
                ic = ill_q.pop_front();
                checks++;
                assert (cycle == ic) else begin
                    $display("Mismatch at %0t: illegal pulse in cycle %0d, expected in cycle %0d",
                             $time, cycle, ic);
                    errors++;
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        locked       = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        for (int k = 0; k < `NUM_REGS; k++)
            model_regs[k] = '0;
        repeat (4) @(posedge clk_10M);
        @(negedge clk_10M);
        locked = 1'b1;

        repeat (6) begin
            @(negedge clk_10M);
            checks++;
            assert (!wb_valid_o && !illegal_o) else begin
                $display("Mismatch at %0t: output pulse with no instruction issued", $time);
                errors++;
            end
        end
        finish_test("idle after reset");

        issue({20'h80001, 5'd1, `OPC_LUI}, 2);
        issue(enc_i(12'h234, 5'd1, `F3_ADD_SUB, 5'd1), 2);
        issue(enc_i(12'h007, 5'd0, `F3_ADD_SUB, 5'd2), 2);  // x2 = 7, opposite sign to x1
        for (int k = 0; k < 8; k++) begin
            issue(enc_r(7'd0, 5'd2, 5'd1, k[2:0], 5'd4), 2);
            issue(enc_i(k[0] ? {7'd0, 5'd13} : 12'h8f3, k[0] ? 5'd1 : 5'd2, k[2:0], 5'd5), 2);
        end
        issue(enc_r(`F7_ALT, 5'd2, 5'd1, `F3_ADD_SUB, 5'd6), 2);
        issue(enc_r(`F7_ALT, 5'd2, 5'd1, `F3_SR, 5'd6), 2);
        issue(enc_i({`F7_ALT, 5'd4}, 5'd1, `F3_SR, 5'd7), 2);
        drain();
        finish_test("single operations");

        for (int d = 1; d <= 3; d++) begin
            issue(enc_i(12'd100 + d[11:0], 5'd0, `F3_ADD_SUB, 5'd1), 0);
            repeat (d - 1) issue(enc_i(12'd1, 5'd0, `F3_ADD_SUB, 5'd7), 0);
            issue(enc_r(7'd0, 5'd1, 5'd1, `F3_ADD_SUB, 5'd2), 0);  // both sources at distance d
            issue(enc_r(`F7_ALT, 5'd1, 5'd2, `F3_ADD_SUB, 5'd3), 0);
            issue(enc_i(12'd5, 5'd3, `F3_XOR, 5'd3), 0);
        end
        drain();
        finish_test("forwarding");

        issue(enc_i(12'd55, 5'd0, `F3_ADD_SUB, 5'd0), 0);
        issue(enc_r(7'd0, 5'd1, 5'd1, `F3_OR, 5'd0), 0);
        issue(enc_r(7'd0, 5'd0, 5'd0, `F3_OR, 5'd4), 0);
        issue(enc_i(12'd9, 5'd0, `F3_ADD_SUB, 5'd5), 0);
        drain();
        finish_test("writes to x0");

        issue(32'h0000_2083, 0);  // lw x1
        issue(32'h0020_8063, 0);  // beq
        issue(enc_r(7'd1, 5'd2, 5'd1, `F3_ADD_SUB, 5'd1), 0);
        issue(enc_i({`F7_ALT, 5'd3}, 5'd2, `F3_SLL, 5'd2), 0);
        issue(enc_r(7'd0, 5'd0, 5'd1, `F3_OR, 5'd4), 0);
        issue(enc_r(7'd0, 5'd0, 5'd2, `F3_OR, 5'd5), 0);
        drain();
        finish_test("illegal encodings");

        for (int n = 0; n < 400; n++) begin
            r = rand_bits(2);
            issue(rand_inst(), (r[1:0] == 2'd0) ? 1 : 0);
        end
        drain();
        finish_test("random mix");

        $display("%0d tests ok, %0d tests failed, %0d checks, %0d errors",
                 tests_ok, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
